/* all.f */
logic/isa_pkg.sv
logic/pipeline_pkg.sv
logic/regfile.sv
logic/decoder.sv
logic/dispatch.sv
logic/execute.sv
logic/ctrl.sv
logic/backend_top.sv
tb/backend_tb.sv

/* logic/backend_top.sv */
`timescale 1ns/10ps
`default_nettype none

module backend_top (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         inst_req_i,
    input  wire pipeline_pkg::inst_in_t inst_i,
    output logic                        inst_ack_o,
    output pipeline_pkg::commit_t       commit_o,
    output pipeline_pkg::redirect_t     redirect_o
);

    pipeline_pkg::dispatch_rec_t dispatch_rec;
    pipeline_pkg::issue_rec_t issue_rec;
    pipeline_pkg::result_rec_t result_rec;
    pipeline_pkg::forward_t ex_fwd;
    pipeline_pkg::forward_t wb_fwd;

    isa_pkg::reg_addr_t rf_raddr_a;
    isa_pkg::reg_addr_t rf_raddr_b;
    isa_pkg::word_t rf_rdata_a;
    isa_pkg::word_t rf_rdata_b;
    logic rf_we;
    isa_pkg::reg_addr_t rf_waddr;
    isa_pkg::word_t rf_wdata;

    logic decode_stall;
    logic dispatch_branch;
    logic issue_branch;

    // branch flags for the stall
    assign dispatch_branch = dispatch_rec.valid &&
                             (dispatch_rec.alu_op inside {isa_pkg::ALU_BEQ, isa_pkg::ALU_BNE});
    assign issue_branch = issue_rec.valid &&
                          (issue_rec.alu_op inside {isa_pkg::ALU_BEQ, isa_pkg::ALU_BNE});

    decoder u_decoder (
        .clk,
        .rst_i,
        .inst_req_i,
        .inst_i,
        .decode_stall_i(decode_stall),
        .inst_ack_o,
        .dispatch_o(dispatch_rec)
    );

    dispatch u_dispatch (
        .clk,
        .rst_i,
        .dispatch_i(dispatch_rec),
        .ex_fwd_i(ex_fwd),
        .wb_fwd_i(wb_fwd),
        .rf_raddr_a_o(rf_raddr_a),
        .rf_raddr_b_o(rf_raddr_b),
        .rf_rdata_a_i(rf_rdata_a),
        .rf_rdata_b_i(rf_rdata_b),
        .issue_o(issue_rec)
    );

    execute u_execute (
        .clk,
        .rst_i,
        .issue_i(issue_rec),
        .result_o(result_rec),
        .ex_fwd_o(ex_fwd)
    );

    regfile u_regfile (
        .clk,
        .rst_i,
        .we_i(rf_we),
        .waddr_i(rf_waddr),
        .wdata_i(rf_wdata),
        .raddr_a_i(rf_raddr_a),
        .raddr_b_i(rf_raddr_b),
        .rdata_a_o(rf_rdata_a),
        .rdata_b_o(rf_rdata_b)
    );

    ctrl u_ctrl (
        .clk,
        .rst_i,
        .result_i(result_rec),
        .dispatch_valid_branch_i(dispatch_branch),
        .issue_valid_branch_i(issue_branch),
        .decode_stall_o(decode_stall),
        .rf_we_o(rf_we),
        .rf_waddr_o(rf_waddr),
        .rf_wdata_o(rf_wdata),
        .wb_fwd_o(wb_fwd),
        .commit_o,
        .redirect_o
    );

endmodule

`default_nettype wire

/* logic/ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrl (
    input  wire                            clk,
    input  wire                            rst_i,
    input  wire pipeline_pkg::result_rec_t result_i,
    input  wire                            dispatch_valid_branch_i,
    input  wire                            issue_valid_branch_i,
    output logic                           decode_stall_o,
    output logic                           rf_we_o,
    output isa_pkg::reg_addr_t             rf_waddr_o,
    output isa_pkg::word_t                 rf_wdata_o,
    output pipeline_pkg::forward_t         wb_fwd_o,
    output pipeline_pkg::commit_t          commit_o,
    output pipeline_pkg::redirect_t        redirect_o
);

    // any branch between decode and the result register holds intake
    assign decode_stall_o = dispatch_valid_branch_i || issue_valid_branch_i ||
                            (result_i.valid && result_i.is_branch);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            commit_o.valid <= 1'b0;
            redirect_o.valid <= 1'b0;
        end else begin
            commit_o.valid <= result_i.valid;
            commit_o.pc <= result_i.pc;
            commit_o.rd <= result_i.rd;
            commit_o.writes_rd <= result_i.writes_rd;
            commit_o.data <= result_i.data;
            redirect_o.valid <= result_i.valid && result_i.is_branch && result_i.taken;
            redirect_o.target <= result_i.data;
        end
    end

    // writeback from the commit register
    assign rf_we_o = commit_o.valid && commit_o.writes_rd && (commit_o.rd != '0);
    assign rf_waddr_o = commit_o.rd;
    assign rf_wdata_o = commit_o.data;
    assign wb_fwd_o = pipeline_pkg::forward_t'{valid: rf_we_o, rd: rf_waddr_o, data: rf_wdata_o};

    // nothing from the wrong path right behind a taken branch
    no_commit_after_redirect : assert property (@(posedge clk) disable iff (rst_i)
        redirect_o.valid |=> !commit_o.valid);

endmodule

`default_nettype wire

/* logic/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  wire                         clk,
    input  wire                         rst_i,
    input  wire                         inst_req_i,
    input  wire pipeline_pkg::inst_in_t inst_i,
    input  wire                         decode_stall_i,
    output logic                        inst_ack_o,
    output pipeline_pkg::dispatch_rec_t dispatch_o
);

    logic accept;
    isa_pkg::word_t word;
    pipeline_pkg::dispatch_rec_t dec;

    // only from an idle handshake
    assign accept = inst_req_i && !inst_ack_o && !decode_stall_i;
    assign word = inst_i.inst;

    always_comb begin
        dec = '0;
        dec.valid = accept;
        dec.pc = inst_i.pc;
        dec.alu_op = isa_pkg::ALU_ADD;
        dec.rj = word[9:5];
        dec.rk_or_rd = word[14:10];
        dec.rd = word[4:0];
        dec.imm = {{20{word[21]}}, word[21:10]};
        if (word[31:22] == isa_pkg::OP_ADDI_W) begin
            dec.use_imm = 1'b1;
            dec.writes_rd = 1'b1;
        end else if (word[31:25] == isa_pkg::OP_LU12I_W) begin
            dec.alu_op = isa_pkg::ALU_LUI;
            dec.imm = {word[24:5], 12'h000};
            dec.use_imm = 1'b1;
            dec.writes_rd = 1'b1;
        end else if (word[31:26] == isa_pkg::OP_BEQ || word[31:26] == isa_pkg::OP_BNE) begin
            dec.alu_op = word[26] ? isa_pkg::ALU_BNE : isa_pkg::ALU_BEQ;
            // rj is compared against rd
            dec.rk_or_rd = word[4:0];
            dec.imm = {{14{word[25]}}, word[25:10], 2'b00};
        end else begin
            dec.writes_rd = 1'b1;
            case (word[31:15])
                isa_pkg::OP_ADD_W: dec.alu_op = isa_pkg::ALU_ADD;
                isa_pkg::OP_SUB_W: dec.alu_op = isa_pkg::ALU_SUB;
                isa_pkg::OP_SLT:   dec.alu_op = isa_pkg::ALU_SLT;
                isa_pkg::OP_AND:   dec.alu_op = isa_pkg::ALU_AND;
                isa_pkg::OP_OR:    dec.alu_op = isa_pkg::ALU_OR;
                isa_pkg::OP_XOR:   dec.alu_op = isa_pkg::ALU_XOR;
                // unknown word retires as a nop
                default:           dec.writes_rd = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            inst_ack_o <= 1'b0;
            dispatch_o.valid <= 1'b0;
        end else begin
            dispatch_o <= dec;
            if (accept) begin
                inst_ack_o <= 1'b1;
            end else if (!inst_req_i) begin
                inst_ack_o <= 1'b0;
            end
        end
    end

    // the source keeps req and the word steady until ack
    req_held_until_ack : assert property (@(posedge clk) disable iff (rst_i)
        (inst_req_i && !inst_ack_o) |=> (inst_req_i && $stable(inst_i)));

endmodule

`default_nettype wire

/* logic/dispatch.sv */
`timescale 1ns/10ps
`default_nettype none

module dispatch (
    input  wire                              clk,
    input  wire                              rst_i,
    input  wire pipeline_pkg::dispatch_rec_t dispatch_i,
    input  wire pipeline_pkg::forward_t      ex_fwd_i,
    input  wire pipeline_pkg::forward_t      wb_fwd_i,
    output isa_pkg::reg_addr_t               rf_raddr_a_o,
    output isa_pkg::reg_addr_t               rf_raddr_b_o,
    input  wire isa_pkg::word_t              rf_rdata_a_i,
    input  wire isa_pkg::word_t              rf_rdata_b_i,
    output pipeline_pkg::issue_rec_t         issue_o
);

    isa_pkg::word_t src_a;
    isa_pkg::word_t src_b;

    // execute beats writeback beats regfile
    function automatic isa_pkg::word_t pick_operand(
        input isa_pkg::reg_addr_t     addr,
        input isa_pkg::word_t         rf_data,
        input pipeline_pkg::forward_t ex_fwd,
        input pipeline_pkg::forward_t wb_fwd
    );
        isa_pkg::word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd.valid && ex_fwd.rd == addr) begin
            val = ex_fwd.data;
        end else if (wb_fwd.valid && wb_fwd.rd == addr) begin
            val = wb_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign rf_raddr_a_o = dispatch_i.rj;
    assign rf_raddr_b_o = dispatch_i.rk_or_rd;

    assign src_a = pick_operand(dispatch_i.rj, rf_rdata_a_i, ex_fwd_i, wb_fwd_i);
    assign src_b = pick_operand(dispatch_i.rk_or_rd, rf_rdata_b_i, ex_fwd_i, wb_fwd_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            issue_o.valid <= 1'b0;
        end else begin
            issue_o.valid <= dispatch_i.valid;
            issue_o.pc <= dispatch_i.pc;
            issue_o.alu_op <= dispatch_i.alu_op;
            issue_o.op_a <= src_a;
            // branches keep the register here and the imm as offset
            issue_o.op_b <= dispatch_i.use_imm ? dispatch_i.imm : src_b;
            issue_o.offset <= dispatch_i.imm;
            issue_o.rd <= dispatch_i.rd;
            issue_o.writes_rd <= dispatch_i.writes_rd;
        end
    end

endmodule

`default_nettype wire

/* logic/execute.sv */
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  wire                           clk,
    input  wire                           rst_i,
    input  wire pipeline_pkg::issue_rec_t issue_i,
    output pipeline_pkg::result_rec_t     result_o,
    output pipeline_pkg::forward_t        ex_fwd_o
);

    isa_pkg::word_t alu_res;
    isa_pkg::word_t target;
    logic operands_equal;
    logic is_branch;
    logic taken;

    always_comb begin
        operands_equal = (issue_i.op_a == issue_i.op_b);
        target = issue_i.pc + issue_i.offset;
        is_branch = 1'b0;
        taken = 1'b0;
        case (issue_i.alu_op)
            isa_pkg::ALU_ADD: alu_res = issue_i.op_a + issue_i.op_b;
            isa_pkg::ALU_SUB: alu_res = issue_i.op_a - issue_i.op_b;
            isa_pkg::ALU_AND: alu_res = issue_i.op_a & issue_i.op_b;
            isa_pkg::ALU_OR:  alu_res = issue_i.op_a | issue_i.op_b;
            isa_pkg::ALU_XOR: alu_res = issue_i.op_a ^ issue_i.op_b;
            isa_pkg::ALU_SLT: alu_res = {31'b0, $signed(issue_i.op_a) < $signed(issue_i.op_b)};
            isa_pkg::ALU_LUI: alu_res = issue_i.op_b;
            isa_pkg::ALU_BEQ: begin
                is_branch = 1'b1;
                taken = operands_equal;
                alu_res = target;
            end
            isa_pkg::ALU_BNE: begin
                is_branch = 1'b1;
                taken = !operands_equal;
                alu_res = target;
            end
            default: alu_res = issue_i.op_a + issue_i.op_b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o.valid <= 1'b0;
        end else begin
            result_o.valid <= issue_i.valid;
            result_o.pc <= issue_i.pc;
            result_o.rd <= issue_i.rd;
            result_o.writes_rd <= issue_i.writes_rd;
            result_o.data <= alu_res;
            result_o.is_branch <= is_branch;
            result_o.taken <= taken;
        end
    end

    assign ex_fwd_o = pipeline_pkg::forward_t'{
        valid: result_o.valid && result_o.writes_rd,
        rd:    result_o.rd,
        data:  result_o.data
    };

    // the decoder must never mark a branch as writing rd
    branch_no_write : assert property (@(posedge clk) disable iff (rst_i)
        (result_o.valid && result_o.is_branch) |-> !result_o.writes_rd);

endmodule

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6,
        ALU_BEQ = 4'd7,
        ALU_BNE = 4'd8
    } alu_op_t;

    // 3R format matched on inst[31:15]
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // 2RI12, 1RI20 and 2RI16 formats
    localparam logic [9:0] OP_ADDI_W  = 10'h00a;
    localparam logic [6:0] OP_LU12I_W = 7'h0a;
    localparam logic [5:0] OP_BEQ     = 6'h16;
    localparam logic [5:0] OP_BNE     = 6'h17;

endpackage

`default_nettype wire

/* logic/pipeline_pkg.sv */
`default_nettype none

package pipeline_pkg;

    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } inst_in_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::reg_addr_t rj;
        // rk for 3R ops, rd for branches
        isa_pkg::reg_addr_t rk_or_rd;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     imm;
        logic               use_imm;
        logic               writes_rd;
    } dispatch_rec_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::alu_op_t   alu_op;
        isa_pkg::word_t     op_a;
        isa_pkg::word_t     op_b;
        isa_pkg::word_t     offset;
        isa_pkg::reg_addr_t rd;
        logic               writes_rd;
    } issue_rec_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rd;
        logic               writes_rd;
        isa_pkg::word_t     data;
        logic               is_branch;
        logic               taken;
    } result_rec_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     data;
    } forward_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rd;
        logic               writes_rd;
        isa_pkg::word_t     data;
    } commit_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::word_t target;
    } redirect_t;

endpackage

`default_nettype wire

/* logic/regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire                     we_i,
    input  wire isa_pkg::reg_addr_t waddr_i,
    input  wire isa_pkg::word_t     wdata_i,
    input  wire isa_pkg::reg_addr_t raddr_a_i,
    input  wire isa_pkg::reg_addr_t raddr_b_i,
    output isa_pkg::word_t          rdata_a_o,
    output isa_pkg::word_t          rdata_b_o
);

    isa_pkg::word_t regs [32];

    // r0 is cleared at reset and never written
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs[raddr_a_i];
    assign rdata_b_o = regs[raddr_b_i];

endmodule

`default_nettype wire

/* tb/backend_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module backend_tb;

    localparam int MAX_ENTRIES = 64;
    localparam int TIMEOUT_CYCLES = 50;

    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::word_t     inst;
        logic               writes_rd;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     data;
        logic               redirect;
        isa_pkg::word_t     target;
    } trace_entry_t;

    logic clk;
    logic rst_i;
    logic inst_req_i;
    pipeline_pkg::inst_in_t inst_i;
    logic inst_ack_o;
    pipeline_pkg::commit_t commit_o;
    pipeline_pkg::redirect_t redirect_o;

    trace_entry_t entries [MAX_ENTRIES];
    string names [MAX_ENTRIES];
    int num_entries;
    int errors;
    int checks;

    logic branch_pending;
    isa_pkg::word_t branch_pc;
    logic ack_q;

    backend_top dut_i (
        .clk,
        .rst_i,
        .inst_req_i,
        .inst_i,
        .inst_ack_o,
        .commit_o,
        .redirect_o
    );

    always #50 clk = ~clk;

    // beq and bne major opcodes
    function automatic logic is_branch_word(input logic [31:0] word);
        return (word[31:26] == 6'b010110) || (word[31:26] == 6'b010111);
    endfunction

    task automatic compare_field(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic load_trace();
        int fd;
        int n;
        string line;
        string name;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] wr;
        logic [31:0] rd;
        logic [31:0] data;
        logic [31:0] redir;
        logic [31:0] target;
        fd = $fopen("tb/backend_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/backend_trace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0 && num_entries < MAX_ENTRIES) begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                        name, pc, inst, wr, rd, data, redir, target);
            if (n != 8) begin
                $display("malformed trace line: %s", line);
                errors++;
                continue;
            end
            names[num_entries] = name;
            entries[num_entries].pc = pc;
            entries[num_entries].inst = inst;
            entries[num_entries].writes_rd = wr[0];
            entries[num_entries].rd = rd[4:0];
            entries[num_entries].data = data;
            entries[num_entries].redirect = redir[0];
            entries[num_entries].target = target;
            num_entries++;
        end
        $fclose(fd);
        if (num_entries == 0) begin
            $display("the trace holds no instructions");
            errors++;
        end
    endtask

    task automatic wait_for_ack(input logic level, input string name, output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        while (cycles < TIMEOUT_CYCLES && !ok) begin
            @(negedge clk);
            if (inst_ack_o === level) begin
                ok = 1'b1;
            end
            cycles++;
        end
        if (!ok) begin
            $display("%s: ack did not go to %0b within %0d cycles",
                     name, level, TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    // four-phase req/ack per instruction with a random idle gap after each
    task automatic drive_trace();
        logic ok;
        int gap;
        for (int i = 0; i < num_entries; i++) begin
            @(posedge clk);
            inst_req_i <= 1'b1;
            inst_i.pc <= entries[i].pc;
            inst_i.inst <= entries[i].inst;
            wait_for_ack(1'b1, names[i], ok);
            if (!ok) begin
                break;
            end
            @(posedge clk);
            inst_req_i <= 1'b0;
            wait_for_ack(1'b0, names[i], ok);
            if (!ok) begin
                break;
            end
            gap = $urandom % 4;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic check_commits();
        int cycles;
        logic seen;
        for (int i = 0; i < num_entries; i++) begin
            cycles = 0;
            seen = 1'b0;
            while (cycles < TIMEOUT_CYCLES && !seen) begin
                @(negedge clk);
                if (commit_o.valid === 1'b1) begin
                    seen = 1'b1;
                end
                cycles++;
            end
            if (!seen) begin
                $display("%s: no commit within %0d cycles", names[i], TIMEOUT_CYCLES);
                errors++;
                break;
            end
            compare_field(names[i], "pc", entries[i].pc, commit_o.pc);
            compare_field(names[i], "writes_rd", 32'(entries[i].writes_rd), 32'(commit_o.writes_rd));
            compare_field(names[i], "rd", 32'(entries[i].rd), 32'(commit_o.rd));
            compare_field(names[i], "data", entries[i].data, commit_o.data);
            compare_field(names[i], "redirect", 32'(entries[i].redirect), 32'(redirect_o.valid));
            if (entries[i].redirect) begin
                compare_field(names[i], "target", entries[i].target, redirect_o.target);
            end
        end
    endtask

    // no new ack while an accepted branch is still short of commit
    always @(negedge clk) begin
        if (rst_i) begin
            branch_pending = 1'b0;
            ack_q = 1'b0;
        end else begin
            if (branch_pending && commit_o.valid === 1'b1 && commit_o.pc === branch_pc) begin
                branch_pending = 1'b0;
            end
            if (inst_ack_o === 1'b1 && !ack_q) begin
                if (branch_pending) begin
                    $display("ack rose for pc %h before the branch at pc %h committed",
                             inst_i.pc, branch_pc);
                    errors++;
                end
                if (is_branch_word(inst_i.inst)) begin
                    branch_pending = 1'b1;
                    branch_pc = inst_i.pc;
                end
            end
            ack_q = inst_ack_o;
        end
    end

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rst_i = 1'b1;
        inst_req_i = 1'b0;
        inst_i = '0;
        errors = 0;
        checks = 0;
        num_entries = 0;
        void'($urandom(93110));
        load_trace();
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        // outputs idle before the first request
        @(negedge clk);
        compare_field("reset", "inst_ack_o", 32'd0, 32'(inst_ack_o));
        compare_field("reset", "commit_valid", 32'd0, 32'(commit_o.valid));
        compare_field("reset", "redirect_valid", 32'd0, 32'(redirect_o.valid));
        if (num_entries > 0) begin
            fork
                drive_trace();
                check_commits();
            join
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

/* tb/backend_trace.txt */
# columns: name pc inst writes_rd rd data redirect target (all but name in hex)
# target is only compared when redirect is 1
lu12i_r1         1c000000 142468a1 1 01 12345000 0 00000000
addi_r1_dep      1c000004 0299e021 1 01 12345678 0 00000000
addi_r2_neg      1c000008 02bffc02 1 02 ffffffff 0 00000000
add_r3           1c00000c 00100823 1 03 12345677 0 00000000
sub_r4           1c000010 00110824 1 04 12345679 0 00000000
and_r5           1c000014 00148825 1 05 12345678 0 00000000
or_r6_r0         1c000018 00150066 1 06 12345677 0 00000000
xor_r7           1c00001c 00158c27 1 07 0000000f 0 00000000
slt_r8_true      1c000020 00120448 1 08 00000001 0 00000000
slt_r9_false     1c000024 00120829 1 09 00000000 0 00000000
addi_r0_write    1c000028 02801420 1 00 1234567d 0 00000000
add_r10_read_r0  1c00002c 0010040a 1 0a 12345678 0 00000000
beq_taken        1c000030 58001025 0 05 1c000040 1 1c000040
bne_not_taken    1c000040 5ffff866 0 06 1c000038 0 00000000
bne_taken        1c000044 5c0008e0 0 00 1c00004c 1 1c00004c
beq_not_taken    1c00004c 58000d09 0 09 1c000058 0 00000000
addi_after_br    1c000050 02bfc0eb 1 0b ffffffff 0 00000000
unknown_nop      1c000054 ffffffff 0 1f 00000000 0 00000000
sub_r13          1c000058 00112c0d 1 0d 00000001 0 00000000
